// File: rtl/ooo_retire_pkg.sv
package ooo_retire_pkg;

    // Datapath widths
    localparam int XLEN       = 32;
    localparam int PC_W       = 32;
    localparam int REG_ADDR_W = 5;

    // Reorder buffer sizing
    // Depth must stay a power of two so the pointers wrap naturally
    localparam int ROB_DEPTH = 8;
    localparam int TAG_W     = $clog2(ROB_DEPTH);

    // Execution latency and result bus buffering
    localparam int MUL_STAGES      = 3;
    localparam int CDB_QUEUE_DEPTH = 4;
    localparam int CDB_QPTR_W      = $clog2(CDB_QUEUE_DEPTH);

    // Exception causes
    localparam int                 CAUSE_W       = 32;
    localparam logic [CAUSE_W-1:0] CAUSE_ILLEGAL = CAUSE_W'(2);

    // Operation codes
    localparam int OP_W = 4;

    // Codes 9 and up are illegal
    typedef enum logic [OP_W-1:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLL  = 4'd5,
        OP_SRL  = 4'd6,
        OP_MUL  = 4'd7,
        OP_MULH = 4'd8
    } op_e;

    // Steers an operation to the multiplier, everything else goes to the ALU
    function automatic logic is_mul_op(op_e op);
        return (op == OP_MUL) || (op == OP_MULH);
    endfunction

endpackage

// File: rtl/cdb_if.sv
interface cdb_if
    import ooo_retire_pkg::*;
();

    // One completed result per cycle, no handshake
    // A high valid is a write in that very cycle
    logic               valid;
    logic [TAG_W-1:0]   tag;
    logic [XLEN-1:0]    result;

    // Exception reported by the execution unit
    logic               exc_valid;
    logic [CAUSE_W-1:0] exc_cause;

    // Producer side, an execution unit or the arbiter
    modport source (
        output valid,
        output tag,
        output result,
        output exc_valid,
        output exc_cause
    );

    // Consumer side, the arbiter or the reorder buffer
    modport sink (
        input valid,
        input tag,
        input result,
        input exc_valid,
        input exc_cause
    );

endinterface

// File: rtl/alu_unit.sv
module alu_unit
    import ooo_retire_pkg::*;
(
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             flush_i,
    input  logic             issue_i,
    input  logic [TAG_W-1:0] tag_i,
    input  op_e              op_i,
    input  logic [XLEN-1:0]  a_i,
    input  logic [XLEN-1:0]  b_i,
    cdb_if.source            cdb
);

    // Issue decode and combinational result
    logic             accept;
    logic [XLEN-1:0]  result_d;
    logic             illegal_d;

    // Output register
    logic             valid_q;
    logic [TAG_W-1:0] tag_q;
    logic [XLEN-1:0]  result_q;
    logic             illegal_q;

    // Multiplier codes belong to the other unit
    // Unknown codes stay here and turn into an exception
    assign accept = issue_i && !is_mul_op(op_i);

    // -------------------------------------------------------------------------
    // Operation decode
    // -------------------------------------------------------------------------
    always_comb begin
        result_d  = '0;
        illegal_d = 1'b0;
        case (op_i)
            OP_ADD:  result_d = a_i + b_i;
            OP_SUB:  result_d = a_i - b_i;
            OP_AND:  result_d = a_i & b_i;
            OP_OR:   result_d = a_i | b_i;
            OP_XOR:  result_d = a_i ^ b_i;
            // Shift amount from the low five bits only
            OP_SLL:  result_d = a_i << b_i[4:0];
            OP_SRL:  result_d = a_i >> b_i[4:0];
            // Result stays zero for an illegal code
            default: illegal_d = 1'b1;
        endcase
    end

    // -------------------------------------------------------------------------
    // Result register
    // -------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= accept;
        end
    end

    // Payload only loads on an accepted issue
    always_ff @(posedge clk_i) begin
        if (accept) begin
            tag_q     <= tag_i;
            result_q  <= result_d;
            illegal_q <= illegal_d;
        end
    end

    // Drive the unit's result bus
    assign cdb.valid     = valid_q;
    assign cdb.tag       = tag_q;
    assign cdb.result    = result_q;
    assign cdb.exc_valid = illegal_q;
    assign cdb.exc_cause = illegal_q ? CAUSE_ILLEGAL : '0;

endmodule

// File: rtl/mul_unit.sv
module mul_unit
    import ooo_retire_pkg::*;
(
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             flush_i,
    input  logic             issue_i,
    input  logic [TAG_W-1:0] tag_i,
    input  op_e              op_i,
    input  logic [XLEN-1:0]  a_i,
    input  logic [XLEN-1:0]  b_i,
    cdb_if.source            cdb
);

    // Stage 0 holds the operands, later stages hold the product
    logic                    accept;
    logic [MUL_STAGES-1:0]   vld_q;
    logic [MUL_STAGES-1:0]   hi_q;
    logic [TAG_W-1:0]        tag_q  [MUL_STAGES];
    logic signed [XLEN-1:0]  a_q;
    logic signed [XLEN-1:0]  b_q;
    logic signed [2*XLEN-1:0] prod_q [1:MUL_STAGES-1];

    assign accept = issue_i && is_mul_op(op_i);

    // -------------------------------------------------------------------------
    // Stage valids
    // -------------------------------------------------------------------------
    // One new operation per cycle, several can be in flight together
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            vld_q <= '0;
        end else if (flush_i) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[MUL_STAGES-2:0], accept};
        end
    end

    // -------------------------------------------------------------------------
    // Datapath stages
    // -------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        // Capture operands and the half select at issue
        if (accept) begin
            a_q      <= a_i;
            b_q      <= b_i;
            tag_q[0] <= tag_i;
            hi_q[0]  <= (op_i == OP_MULH);
        end

        // Signed full-width product
        prod_q[1] <= a_q * b_q;

        // Tag and select follow the product down the pipe
        for (int s = 1; s < MUL_STAGES; s++) begin
            tag_q[s] <= tag_q[s-1];
            hi_q[s]  <= hi_q[s-1];
        end

        // Remaining stages only delay the product
        for (int s = 2; s < MUL_STAGES; s++) begin
            prod_q[s] <= prod_q[s-1];
        end
    end

    // -------------------------------------------------------------------------
    // Result bus
    // -------------------------------------------------------------------------
    assign cdb.valid  = vld_q[MUL_STAGES-1];
    assign cdb.tag    = tag_q[MUL_STAGES-1];

    // MULH returns the upper word, MUL the lower one
    assign cdb.result = hi_q[MUL_STAGES-1] ? prod_q[MUL_STAGES-1][2*XLEN-1:XLEN]
                                           : prod_q[MUL_STAGES-1][XLEN-1:0];

    // The multiplier never raises an exception
    assign cdb.exc_valid = 1'b0;
    assign cdb.exc_cause = '0;

endmodule

// File: rtl/cdb_arbiter.sv
module cdb_arbiter
    import ooo_retire_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_ni,
    input  logic  flush_i,
    cdb_if.sink   alu,
    cdb_if.sink   mul,
    cdb_if.source rob
);

    // One queued ALU completion
    typedef struct packed {
        logic [TAG_W-1:0]   tag;
        logic [XLEN-1:0]    result;
        logic               exc_valid;
        logic [CAUSE_W-1:0] exc_cause;
    } cdb_entry_t;

    cdb_entry_t            queue_mem [CDB_QUEUE_DEPTH];
    cdb_entry_t            queue_head;
    logic [CDB_QPTR_W-1:0] wr_ptr_q;
    logic [CDB_QPTR_W-1:0] rd_ptr_q;
    logic [CDB_QPTR_W:0]   count_q;
    logic                  queue_empty;
    logic                  push;
    logic                  pop;

    assign queue_empty = (count_q == '0);
    assign queue_head  = queue_mem[rd_ptr_q];

    // Queue the ALU result when the bus is taken or older ones still wait
    // This keeps ALU completions in their own order
    assign push = alu.valid && (mul.valid || !queue_empty);
    assign pop  = !mul.valid && !queue_empty;

    // -------------------------------------------------------------------------
    // Holding FIFO
    // -------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            wr_ptr_q <= wr_ptr_q + CDB_QPTR_W'(push);
            rd_ptr_q <= rd_ptr_q + CDB_QPTR_W'(pop);
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            queue_mem[wr_ptr_q] <= '{alu.tag, alu.result, alu.exc_valid, alu.exc_cause};
        end
    end

    // -------------------------------------------------------------------------
    // Bus select
    // -------------------------------------------------------------------------
    // Multiplier first, then the oldest queued result, then a direct ALU pass
    always_comb begin
        if (mul.valid) begin
            rob.valid     = 1'b1;
            rob.tag       = mul.tag;
            rob.result    = mul.result;
            rob.exc_valid = mul.exc_valid;
            rob.exc_cause = mul.exc_cause;
        end else if (!queue_empty) begin
            rob.valid     = 1'b1;
            rob.tag       = queue_head.tag;
            rob.result    = queue_head.result;
            rob.exc_valid = queue_head.exc_valid;
            rob.exc_cause = queue_head.exc_cause;
        end else begin
            rob.valid     = alu.valid;
            rob.tag       = alu.tag;
            rob.result    = alu.result;
            rob.exc_valid = alu.exc_valid;
            rob.exc_cause = alu.exc_cause;
        end
    end

endmodule

// File: rtl/reorder_buffer.sv
module reorder_buffer
    import ooo_retire_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  flush_i,

    // Dispatch side
    input  logic                  dispatch_valid_i,
    input  logic [PC_W-1:0]       dispatch_pc_i,
    input  logic [REG_ADDR_W-1:0] dispatch_rd_i,
    output logic                  dispatch_ready_o,
    output logic                  issue_o,
    output logic [TAG_W-1:0]      issue_tag_o,

    // Completed results
    cdb_if.sink                   cdb,

    // Commit side
    input  logic                  commit_ready_i,
    output logic                  commit_valid_o,
    output logic [PC_W-1:0]       commit_pc_o,
    output logic [REG_ADDR_W-1:0] commit_rd_o,
    output logic [XLEN-1:0]       commit_result_o,
    output logic                  commit_exc_valid_o,
    output logic [CAUSE_W-1:0]    commit_exc_cause_o
);

    // One in-flight instruction
    typedef struct packed {
        logic [PC_W-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       result;
        logic                  exc_valid;
        logic [CAUSE_W-1:0]    exc_cause;
        logic                  ready;
    } rob_entry_t;

    rob_entry_t       entries_q [ROB_DEPTH];
    rob_entry_t       head_entry;

    // Circular buffer control
    logic [TAG_W-1:0] head_q;
    logic [TAG_W-1:0] tail_q;
    logic [TAG_W:0]   count_q;
    logic             full;
    logic             empty;
    logic             do_commit;

    assign full  = (count_q == (TAG_W + 1)'(ROB_DEPTH));
    assign empty = (count_q == '0);

    // -------------------------------------------------------------------------
    // Dispatch and issue
    // -------------------------------------------------------------------------
    // Flush wins over a dispatch in the same cycle
    assign dispatch_ready_o = !full && !flush_i;
    assign issue_o          = dispatch_valid_i && dispatch_ready_o;

    // New instruction takes the tail slot
    assign issue_tag_o = tail_q;

    // -------------------------------------------------------------------------
    // Commit from the head
    // -------------------------------------------------------------------------
    assign head_entry = entries_q[head_q];

    // Head holds still while commit_ready_i is low
    assign commit_valid_o     = !empty && head_entry.ready;
    assign commit_pc_o        = head_entry.pc;
    assign commit_rd_o        = head_entry.rd;
    assign commit_result_o    = head_entry.result;
    assign commit_exc_valid_o = head_entry.exc_valid;
    assign commit_exc_cause_o = head_entry.exc_cause;

    assign do_commit = commit_valid_o && commit_ready_i;

    // -------------------------------------------------------------------------
    // Pointers and entry count
    // -------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            // Drop everything in flight, new tags restart at zero
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            tail_q <= tail_q + TAG_W'(issue_o);
            head_q <= head_q + TAG_W'(do_commit);
            if (issue_o && !do_commit) begin
                count_q <= count_q + 1'b1;
            end else if (do_commit && !issue_o) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // -------------------------------------------------------------------------
    // Entry storage
    // -------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        // Allocation clears the ready flag and any old exception
        if (issue_o) begin
            entries_q[tail_q].pc        <= dispatch_pc_i;
            entries_q[tail_q].rd        <= dispatch_rd_i;
            entries_q[tail_q].exc_valid <= 1'b0;
            entries_q[tail_q].ready     <= 1'b0;
        end

        // Bus write by tag
        // Never hits the tail slot being allocated in the same cycle
        if (cdb.valid) begin
            entries_q[cdb.tag].result    <= cdb.result;
            entries_q[cdb.tag].exc_valid <= cdb.exc_valid;
            entries_q[cdb.tag].exc_cause <= cdb.exc_cause;
            entries_q[cdb.tag].ready     <= 1'b1;
        end
    end

endmodule

// File: rtl/ooo_retire_top.sv
module ooo_retire_top
    import ooo_retire_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  flush_i,

    // Dispatch
    input  logic                  dispatch_valid_i,
    output logic                  dispatch_ready_o,
    input  logic [PC_W-1:0]       dispatch_pc_i,
    input  logic [REG_ADDR_W-1:0] dispatch_rd_i,
    input  logic [OP_W-1:0]       dispatch_op_i,
    input  logic [XLEN-1:0]       dispatch_a_i,
    input  logic [XLEN-1:0]       dispatch_b_i,
    output logic [TAG_W-1:0]      dispatch_tag_o,

    // Commit
    output logic                  commit_valid_o,
    input  logic                  commit_ready_i,
    output logic [PC_W-1:0]       commit_pc_o,
    output logic [REG_ADDR_W-1:0] commit_rd_o,
    output logic [XLEN-1:0]       commit_result_o,
    output logic                  commit_exc_valid_o,
    output logic [CAUSE_W-1:0]    commit_exc_cause_o
);

    logic             issue;
    logic [TAG_W-1:0] issue_tag;
    op_e              dispatch_op;

    // Raw code may be outside the enum, the ALU flags it as illegal
    assign dispatch_op    = op_e'(dispatch_op_i);
    assign dispatch_tag_o = issue_tag;

    // Unit outputs and the merged bus
    cdb_if alu_cdb ();
    cdb_if mul_cdb ();
    cdb_if rob_cdb ();

    reorder_buffer u_reorder_buffer (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .flush_i            (flush_i),
        .dispatch_valid_i   (dispatch_valid_i),
        .dispatch_pc_i      (dispatch_pc_i),
        .dispatch_rd_i      (dispatch_rd_i),
        .dispatch_ready_o   (dispatch_ready_o),
        .issue_o            (issue),
        .issue_tag_o        (issue_tag),
        .cdb                (rob_cdb),
        .commit_ready_i     (commit_ready_i),
        .commit_valid_o     (commit_valid_o),
        .commit_pc_o        (commit_pc_o),
        .commit_rd_o        (commit_rd_o),
        .commit_result_o    (commit_result_o),
        .commit_exc_valid_o (commit_exc_valid_o),
        .commit_exc_cause_o (commit_exc_cause_o)
    );

    // Both units see every issue and pick their own class
    alu_unit u_alu_unit (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (flush_i),
        .issue_i (issue),
        .tag_i   (issue_tag),
        .op_i    (dispatch_op),
        .a_i     (dispatch_a_i),
        .b_i     (dispatch_b_i),
        .cdb     (alu_cdb)
    );

    mul_unit u_mul_unit (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (flush_i),
        .issue_i (issue),
        .tag_i   (issue_tag),
        .op_i    (dispatch_op),
        .a_i     (dispatch_a_i),
        .b_i     (dispatch_b_i),
        .cdb     (mul_cdb)
    );

    cdb_arbiter u_cdb_arbiter (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (flush_i),
        .alu     (alu_cdb),
        .mul     (mul_cdb),
        .rob     (rob_cdb)
    );

endmodule

// File: test/ooo_retire_props.sv
module ooo_retire_props
    import ooo_retire_pkg::*;
(
    input logic             clk_i,
    input logic             rst_ni,
    input logic             flush_i,
    input logic             issue_i,
    input logic [TAG_W:0]   count_i,
    input logic             commit_ready_i,
    input logic             commit_valid_i,
    input logic [PC_W-1:0]  commit_pc_i,
    input logic [XLEN-1:0]  commit_result_i
);

    // A stalled head keeps its place and its payload
    property stall_holds_head;
        @(posedge clk_i) disable iff (!rst_ni)
        (commit_valid_i && !commit_ready_i && !flush_i) |=>
            (commit_valid_i && $stable(commit_pc_i) && $stable(commit_result_i));
    endproperty

    // Flush empties the buffer, nothing is left to commit
    property flush_clears_commit;
        @(posedge clk_i) disable iff (!rst_ni)
        flush_i |=> !commit_valid_i;
    endproperty

    // No allocation into a full buffer
    property no_issue_when_full;
        @(posedge clk_i) disable iff (!rst_ni)
        (count_i == (TAG_W + 1)'(ROB_DEPTH)) |-> !issue_i;
    endproperty

    assert property (stall_holds_head)
        else $error("Commit outputs changed while the head was stalled");
    assert property (flush_clears_commit)
        else $error("Commit valid was high in the cycle after a flush");
    assert property (no_issue_when_full)
        else $error("Issue raised while the reorder buffer was full");

endmodule

// Attach to every reorder buffer instance
bind reorder_buffer ooo_retire_props u_ooo_retire_props (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .issue_i         (issue_o),
    .count_i         (count_q),
    .commit_ready_i  (commit_ready_i),
    .commit_valid_i  (commit_valid_o),
    .commit_pc_i     (commit_pc_o),
    .commit_result_i (commit_result_o)
);

// File: test/ooo_retire_tb.sv
module ooo_retire_tb
    import ooo_retire_pkg::*;
();

    localparam int CLK_PERIOD  = 100;
    localparam int DRIVE_DELAY = 10;
    localparam int RST_CYCLES  = 10;
    localparam int N_RANDOM    = 200;
    localparam int N_ILLEGAL   = 12;
    // Rough length of all phases, a hung run stops at twice that
    localparam int STIM_CYCLES    = RST_CYCLES + 7 * 4 + N_RANDOM * 2 + N_ILLEGAL * 3 + 120;
    localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES;

    // One instruction as it must leave the buffer
    typedef struct packed {
        logic [PC_W-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       result;
        logic                  exc_valid;
        logic [CAUSE_W-1:0]    exc_cause;
    } exp_t;

    logic                  clk_i;
    logic                  rst_ni;
    logic                  flush_i;
    logic                  dispatch_valid_i;
    logic                  dispatch_ready_o;
    logic [PC_W-1:0]       dispatch_pc_i;
    logic [REG_ADDR_W-1:0] dispatch_rd_i;
    logic [OP_W-1:0]       dispatch_op_i;
    logic [XLEN-1:0]       dispatch_a_i;
    logic [XLEN-1:0]       dispatch_b_i;
    logic [TAG_W-1:0]      dispatch_tag_o;
    logic                  commit_valid_o;
    logic                  commit_ready_i;
    logic [PC_W-1:0]       commit_pc_o;
    logic [REG_ADDR_W-1:0] commit_rd_o;
    logic [XLEN-1:0]       commit_result_o;
    logic                  commit_exc_valid_o;
    logic [CAUSE_W-1:0]    commit_exc_cause_o;

    // Model state
    exp_t             exp_q [$];
    logic [TAG_W-1:0] exp_tag;
    logic [31:0]      rng_state;
    logic [31:0]      rdy_state;
    logic [1:0]       ready_mode;
    logic [PC_W-1:0]  next_pc;
    int               cycle_count;

    ooo_retire_top u_ooo_retire_top (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // --------------------------------------------------------------------------
    // Helpers
    // --------------------------------------------------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // About a third multiplier work, the rest spread over the ALU codes
    function automatic logic [OP_W-1:0] random_op();
        logic [31:0] r;
        r = next_random();
        if (r[2:0] < 3) begin
            return r[3] ? OP_MULH : OP_MUL;
        end
        return OP_W'(r[15:8] % 7);
    endfunction

    // Expected result and exception straight from the operation rules
    function automatic void ref_exec(input logic [OP_W-1:0] op, input logic [XLEN-1:0] a,
                                     input logic [XLEN-1:0] b, output logic [XLEN-1:0] res,
                                     output logic exc);
        logic signed [2*XLEN-1:0] prod;
        prod = $signed(a) * $signed(b);
        exc  = 1'b0;
        case (op)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_SLL:  res = a << b[4:0];
            OP_SRL:  res = a >> b[4:0];
            OP_MUL:  res = prod[XLEN-1:0];
            OP_MULH: res = prod[2*XLEN-1:XLEN];
            default: begin
                res = '0;
                exc = 1'b1;
            end
        endcase
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] want);
        assert (got === want)
            else fail_run($sformatf("MISMATCH time=%0t signal=%s got=%h expected=%h",
                                    $time, name, got, want));
    endtask

    // Starts and ends at a drive point, waits while the buffer is full
    task automatic dispatch_op(input logic [OP_W-1:0] op);
        dispatch_valid_i = 1'b1;
        dispatch_op_i    = op;
        dispatch_a_i     = next_random();
        dispatch_b_i     = next_random();
        dispatch_rd_i    = REG_ADDR_W'(next_random());
        dispatch_pc_i    = next_pc;
        next_pc          = next_pc + 4;
        @(negedge clk_i);
        while (!dispatch_ready_o) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #DRIVE_DELAY;
        dispatch_valid_i = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk_i);
        #DRIVE_DELAY;
    endtask

    task automatic wait_drain();
        @(posedge clk_i);
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
        end
        #DRIVE_DELAY;
    endtask

    // --------------------------------------------------------------------------
    // Commit back-pressure with the mode latched at the edge
    // --------------------------------------------------------------------------
    always @(posedge clk_i) begin : drive_commit_ready
        logic [1:0] mode_now;
        mode_now = ready_mode;
        #DRIVE_DELAY;
        rdy_state = xorshift(rdy_state);
        case (mode_now)
            2'd0:    commit_ready_i = 1'b1;
            2'd1:    commit_ready_i = (rdy_state[1:0] != 2'b00);
            default: commit_ready_i = 1'b0;
        endcase
    end

    // Sampled mid-cycle where every input and output is settled
    always @(negedge clk_i) begin : compare_commits
        exp_t             head;
        exp_t             entry;
        logic [XLEN-1:0]  res;
        logic             exc;
        if (rst_ni && flush_i) begin
            // Everything in flight is dropped, tags restart at zero
            exp_q.delete();
            exp_tag = '0;
        end else if (rst_ni) begin
            if (commit_valid_o && commit_ready_i) begin
                assert (exp_q.size() > 0)
                    else fail_run("A commit appeared with no instruction outstanding");
                head = exp_q.pop_front();
                check_value("commit_pc_o", commit_pc_o, head.pc);
                check_value("commit_rd_o", XLEN'(commit_rd_o), XLEN'(head.rd));
                check_value("commit_result_o", commit_result_o, head.result);
                check_value("commit_exc_valid_o", XLEN'(commit_exc_valid_o),
                            XLEN'(head.exc_valid));
                if (head.exc_valid) begin
                    check_value("commit_exc_cause_o", commit_exc_cause_o, head.exc_cause);
                end
            end
            if (dispatch_valid_i && dispatch_ready_o) begin
                // Tags come from the tail in allocation order
                check_value("dispatch_tag_o", XLEN'(dispatch_tag_o), XLEN'(exp_tag));
                ref_exec(dispatch_op_i, dispatch_a_i, dispatch_b_i, res, exc);
                entry.pc        = dispatch_pc_i;
                entry.rd        = dispatch_rd_i;
                entry.result    = res;
                entry.exc_valid = exc;
                entry.exc_cause = exc ? CAUSE_ILLEGAL : '0;
                exp_q.push_back(entry);
                exp_tag = exp_tag + 1'b1;
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("Timeout after %0d cycles with %0d instructions outstanding",
                               cycle_count, exp_q.size()));
        end
    end

    // --------------------------------------------------------------------------
    // Stimulus phases
    // --------------------------------------------------------------------------
    initial begin
        clk_i            = 1'b0;
        rst_ni           = 1'b0;
        flush_i          = 1'b0;
        dispatch_valid_i = 1'b0;
        dispatch_pc_i    = '0;
        dispatch_rd_i    = '0;
        dispatch_op_i    = '0;
        dispatch_a_i     = '0;
        dispatch_b_i     = '0;
        commit_ready_i   = 1'b1;
        rng_state        = 32'd38293;
        rdy_state        = xorshift(32'd38293);
        ready_mode       = 2'd0;
        next_pc          = 32'h0000_1000;
        exp_tag          = '0;
        cycle_count      = 0;
        idle_cycles(RST_CYCLES);
        rst_ni = 1'b1;
        idle_cycles(2);

        // Each ALU code on its own
        for (int op = OP_ADD; op <= OP_SRL; op++) begin
            dispatch_op(OP_W'(op));
            wait_drain();
        end

        // Mixed stream with random commit stalls
        ready_mode = 2'd1;
        for (int i = 0; i < N_RANDOM; i++) begin
            dispatch_op(random_op());
        end
        ready_mode = 2'd0;
        wait_drain();

        // Illegal codes among ordinary work
        for (int i = 0; i < N_ILLEGAL; i++) begin
            if (i % 3 == 0) begin
                dispatch_op(OP_W'(9 + (next_random() % 7)));
            end else begin
                dispatch_op(random_op());
            end
        end
        wait_drain();

        // Fill the buffer with commit blocked
        ready_mode = 2'd2;
        idle_cycles(2);
        for (int i = 0; i < ROB_DEPTH; i++) begin
            assert (dispatch_ready_o)
                else fail_run("Dispatch ready fell before the buffer was full");
            dispatch_op(random_op());
        end
        dispatch_valid_i = 1'b1;
        dispatch_op_i    = OP_ADD;
        repeat (6) begin
            @(negedge clk_i);
            assert (!dispatch_ready_o)
                else fail_run("Dispatch ready stayed high with a full buffer");
        end
        @(posedge clk_i);
        #DRIVE_DELAY;
        dispatch_valid_i = 1'b0;
        ready_mode       = 2'd0;
        wait_drain();

        // Flush with work in flight, then start again from tag zero
        ready_mode = 2'd2;
        idle_cycles(2);
        for (int i = 0; i < 4; i++) begin
            dispatch_op(random_op());
        end
        flush_i = 1'b1;
        idle_cycles(1);
        flush_i    = 1'b0;
        ready_mode = 2'd0;
        idle_cycles(8);
        for (int i = 0; i < 6; i++) begin
            dispatch_op(random_op());
        end
        wait_drain();

        // Buffer must sit empty and open once the last commit is done
        if (commit_valid_o || !dispatch_ready_o) begin
            fail_run("The reorder buffer was not empty after the last commit");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

// File: ooo_retire.f
rtl/ooo_retire_pkg.sv
rtl/cdb_if.sv
rtl/alu_unit.sv
rtl/mul_unit.sv
rtl/cdb_arbiter.sv
rtl/reorder_buffer.sv
rtl/ooo_retire_top.sv
test/ooo_retire_props.sv
test/ooo_retire_tb.sv
